// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_vfifo
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== burst_reader/burst_reader.sv ====
module burst_reader (
    input  logic             S_AXI_ACLK,
    input  logic             S_AXI_ARESETN,
    input  logic             i_m_fire,
    output logic             o_arvalid,
    input  logic             i_arready,
    output vfifo_pkg::addr_t o_araddr,
    input  logic             i_rvalid,
    input  logic             i_rlast,
    vfifo_ledger_if.reader   ledger
);

    vfifo_pkg::fifo_cnt_t          space_res;
    vfifo_pkg::burst_cnt_t         rd_pending;
    logic [vfifo_pkg::BURST_W-2:0] ar_idx;
    logic                          start;
    logic                          rd_issue_q;
    logic                          rd_done;

    assign rd_done = i_rvalid && i_rlast;

    ////////////////////////////////////////////////////////////
    // Start of a read burst
    ////////////////////////////////////////////////////////////

    // Room for a whole burst in the output FIFO
    // Data ledger lags one cycle behind rd_issue so skip that cycle
    assign start = (space_res >= vfifo_pkg::fifo_cnt_t'(vfifo_pkg::BURST_LEN))
        && ledger.data_ok && !ledger.hold && !rd_issue_q
        && (!o_arvalid || i_arready);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            o_arvalid  <= 1'b0;
            rd_issue_q <= 1'b0;
        end else begin
            rd_issue_q <= start;
            if (!o_arvalid || i_arready) begin
                o_arvalid <= start;
            end
        end
    end

    // Output FIFO space not yet promised to a read
    // R data then never needs back-pressure
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || ledger.hold) begin
            space_res <= vfifo_pkg::fifo_cnt_t'(1 << vfifo_pkg::LG_FIFO);
        end else begin
            space_res <= space_res + i_m_fire
                - (start ? vfifo_pkg::fifo_cnt_t'(vfifo_pkg::BURST_LEN) : '0);
        end
    end

    // Aligned address and rewind while held
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || (ledger.hold && !o_arvalid)) begin
            ar_idx <= '0;
        end else if (o_arvalid && i_arready) begin
            ar_idx <= ar_idx + 1'b1;
        end
    end

    assign o_araddr = {ar_idx, (vfifo_pkg::LG_BURST + vfifo_pkg::ADDR_LSB)'(0)};

    // Bursts committed whose RLAST has not arrived
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rd_pending <= '0;
        end else begin
            rd_pending <= rd_pending + start - rd_done;
        end
    end

    assign ledger.rd_issue = rd_issue_q;
    assign ledger.rd_done  = rd_done;
    assign ledger.rd_idle  = (rd_pending == '0);

    // Wrap below zero would show up as more than the FIFO depth
    a_res_bound: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        space_res <= vfifo_pkg::fifo_cnt_t'(1 << vfifo_pkg::LG_FIFO));

endmodule

// ==== burst_writer/burst_writer.sv ====
module burst_writer (
    input  logic                 S_AXI_ACLK,
    input  logic                 S_AXI_ARESETN,
    input  vfifo_pkg::fifo_cnt_t i_ififo_count,
    input  vfifo_pkg::data_t     i_ififo_data,
    output logic                 o_ififo_pop,
    output logic                 o_awvalid,
    input  logic                 i_awready,
    output vfifo_pkg::addr_t     o_awaddr,
    output logic                 o_wvalid,
    input  logic                 i_wready,
    output vfifo_pkg::data_t     o_wdata,
    output logic                 o_wlast,
    input  logic                 i_bvalid,
    vfifo_ledger_if.writer       ledger
);

    vfifo_pkg::wr_state_e            state;
    logic [vfifo_pkg::LG_BURST:0]    beats_left;
    logic [vfifo_pkg::BURST_W-2:0]   aw_idx;
    vfifo_pkg::burst_cnt_t           b_pending;
    logic [vfifo_pkg::LG_BURST-1:0]  w_beats;
    logic                            start;
    logic                            wr_issue_q;
    logic                            aw_fire;
    logic                            w_fire;

    // Full burst waiting, memory room, no hold, both channels free
    assign start = (state == vfifo_pkg::IDLE) && !ledger.hold && ledger.space_ok
        && (i_ififo_count >= vfifo_pkg::fifo_cnt_t'(vfifo_pkg::BURST_LEN));

    assign aw_fire = o_awvalid && i_awready;
    assign w_fire  = o_wvalid && i_wready;

    assign o_awvalid   = (state == vfifo_pkg::ADDR_DATA);
    assign o_wvalid    = (beats_left != '0);
    assign o_wlast     = (beats_left == 1);
    assign o_wdata     = i_ififo_data;
    assign o_ififo_pop = w_fire;
    assign o_awaddr    = {aw_idx, (vfifo_pkg::LG_BURST + vfifo_pkg::ADDR_LSB)'(0)};

    ////////////////////////////////////////////////////////////
    // Burst FSM and beat counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state      <= vfifo_pkg::IDLE;
            beats_left <= '0;
            wr_issue_q <= 1'b0;
        end else begin
            wr_issue_q <= start;
            if (start) begin
                beats_left <= (vfifo_pkg::LG_BURST + 1)'(vfifo_pkg::BURST_LEN);
            end else if (w_fire) begin
                beats_left <= beats_left - 1'b1;
            end
            case (state)
                vfifo_pkg::IDLE:
                    if (start) state <= vfifo_pkg::ADDR_DATA;
                // AW may be accepted before, with, or after the last beat
                vfifo_pkg::ADDR_DATA:
                    if (aw_fire) begin
                        state <= (beats_left == '0 || (w_fire && o_wlast))
                            ? vfifo_pkg::IDLE : vfifo_pkg::DRAIN;
                    end
                vfifo_pkg::DRAIN:
                    if (w_fire && o_wlast) state <= vfifo_pkg::IDLE;
                default:
                    state <= vfifo_pkg::IDLE;
            endcase
        end
    end

    // Aligned burst address steps on accept and rewinds under hold
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || (ledger.hold && !o_awvalid)) begin
            aw_idx <= '0;
        end else if (aw_fire) begin
            aw_idx <= aw_idx + 1'b1;
        end
    end

    // Bursts started but not yet answered on B
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            b_pending <= '0;
        end else begin
            b_pending <= b_pending + start - i_bvalid;
        end
    end

    assign ledger.wr_issue = wr_issue_q;
    assign ledger.wr_done  = i_bvalid;
    assign ledger.wr_idle  = (b_pending == '0);

    // Free-running beat position across bursts
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            w_beats <= '0;
        end else if (w_fire) begin
            w_beats <= w_beats + 1'b1;
        end
    end

    a_aw_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr));
    a_wlast_8th: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        w_fire |-> (o_wlast == (w_beats == '1)));

endmodule

// ==== common/vfifo_ledger_if.sv ====
interface vfifo_ledger_if;

    // Write side burst events
    logic wr_issue;
    logic wr_done;
    logic wr_idle;

    // Read side burst events
    logic rd_issue;
    logic rd_done;
    logic rd_idle;

    // Permissions from the controller
    logic space_ok;
    logic data_ok;
    logic hold;

    modport writer (
        output wr_issue, wr_done, wr_idle,
        input  space_ok, hold
    );

    modport reader (
        output rd_issue, rd_done, rd_idle,
        input  data_ok, hold
    );

    modport ctrl (
        input  wr_issue, wr_done, wr_idle, rd_issue, rd_done, rd_idle,
        output space_ok, data_ok, hold
    );

endinterface

// ==== common/vfifo_pkg.sv ====
package vfifo_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and burst geometry
    ////////////////////////////////////////////////////////////

    // Stream and AXI data width
    localparam int DATA_W     = 32;
    // Byte address of the memory port, 4 KiB
    localparam int ADDR_W     = 12;
    // Byte offset bits inside one word
    localparam int ADDR_LSB   = 2;
    // Beats in one burst, as log2 and as a count
    localparam int LG_BURST   = 3;
    localparam int BURST_LEN  = 1 << LG_BURST;
    // Depth of the input and output FIFOs holds two bursts
    localparam int LG_FIFO    = LG_BURST + 1;
    // Burst index bits plus one so a full count fits
    localparam int BURST_W    = ADDR_W - LG_BURST - ADDR_LSB + 1;
    // Ring buffer capacity in words and in bursts
    localparam int MEM_WORDS  = 1 << (ADDR_W - ADDR_LSB);
    localparam int MEM_BURSTS = MEM_WORDS / BURST_LEN;

    typedef logic [DATA_W-1:0]          data_t;
    typedef logic [ADDR_W-1:0]          addr_t;
    // 0 to MEM_WORDS inclusive
    typedef logic [$clog2(MEM_WORDS):0] fill_t;
    typedef logic [LG_FIFO:0]           fifo_cnt_t;
    typedef logic [BURST_W-1:0]         burst_cnt_t;
    typedef logic [7:0]                 axlen_t;

    ////////////////////////////////////////////////////////////
    // Fixed AXI attributes
    ////////////////////////////////////////////////////////////
    localparam axlen_t     AXLEN        = axlen_t'(BURST_LEN - 1);
    localparam logic [2:0] AXSIZE       = 3'(ADDR_LSB);
    localparam logic [1:0] AXBURST_INCR = 2'b01;

    // Writer progress through one burst
    typedef enum logic [1:0] {IDLE, ADDR_DATA, DRAIN} wr_state_e;
    // Controller mode
    typedef enum logic {RUN, SOFT_RESET} rst_state_e;

endpackage

// ==== hdl/sync_fifo.sv ====
module sync_fifo (
    input  logic                 S_AXI_ACLK,
    input  logic                 S_AXI_ARESETN,
    input  logic                 i_clr,
    input  logic                 i_push,
    input  vfifo_pkg::data_t     i_data,
    output logic                 o_full,
    output vfifo_pkg::fifo_cnt_t o_count,
    input  logic                 i_pop,
    output vfifo_pkg::data_t     o_data,
    output logic                 o_empty
);

    // Storage has no reset
    vfifo_pkg::data_t mem [1 << vfifo_pkg::LG_FIFO];

    // One extra pointer bit tells full from empty
    vfifo_pkg::fifo_cnt_t wr_ptr;
    vfifo_pkg::fifo_cnt_t rd_ptr;

    logic do_push;
    logic do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    // Occupancy straight from the pointer difference
    assign o_count = wr_ptr - rd_ptr;
    assign o_full  = o_count[vfifo_pkg::LG_FIFO];
    assign o_empty = (o_count == '0);

    // Head word is visible without a pop
    assign o_data = mem[rd_ptr[vfifo_pkg::LG_FIFO-1:0]];

    always_ff @(posedge S_AXI_ACLK) begin
        if (do_push) begin
            mem[wr_ptr[vfifo_pkg::LG_FIFO-1:0]] <= i_data;
        end
    end

    // Pointers, cleared by either reset
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || i_clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Upstream flow control must keep these from happening
    a_no_overrun: assert property (@(posedge S_AXI_ACLK)
        disable iff (!S_AXI_ARESETN || i_clr) i_push |-> !o_full);
    a_no_underrun: assert property (@(posedge S_AXI_ACLK)
        disable iff (!S_AXI_ARESETN || i_clr) i_pop |-> !o_empty);

endmodule

// ==== hdl/vfifo_ctrl.sv ====
module vfifo_ctrl (
    input  logic              S_AXI_ACLK,
    input  logic              S_AXI_ARESETN,
    input  logic              i_soft_reset,
    input  logic              i_s_tvalid,
    input  vfifo_pkg::data_t  i_s_tdata,
    input  logic              i_ififo_full,
    output logic              o_s_tready,
    input  logic              i_m_fire,
    output logic              o_fifo_clr,
    output vfifo_pkg::fill_t  o_fill,
    output logic              o_empty,
    output logic              o_overflow,
    vfifo_ledger_if.ctrl      ledger
);

    vfifo_pkg::rst_state_e state;
    vfifo_pkg::burst_cnt_t mem_space;
    vfifo_pkg::burst_cnt_t mem_data;
    vfifo_pkg::data_t      s_last_data;
    logic                  s_stalled;
    logic                  vf_full;
    logic                  s_fire;

    ////////////////////////////////////////////////////////////
    // Soft reset
    ////////////////////////////////////////////////////////////

    // Comes out of hardware reset through one soft reset cycle
    // Stays until both bus halves have gone quiet
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || i_soft_reset) begin
            state <= vfifo_pkg::SOFT_RESET;
        end else if (ledger.wr_idle && ledger.rd_idle) begin
            state <= vfifo_pkg::RUN;
        end
    end

    assign ledger.hold = (state == vfifo_pkg::SOFT_RESET);
    assign o_fifo_clr  = (state == vfifo_pkg::SOFT_RESET);

    // Input accepted only while running with room everywhere
    assign o_s_tready = (state == vfifo_pkg::RUN) && !i_ififo_full && !vf_full;
    assign s_fire     = i_s_tvalid && o_s_tready;

    ////////////////////////////////////////////////////////////
    // Virtual fill with empty and full flags
    ////////////////////////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || ledger.hold) begin
            o_fill  <= '0;
            o_empty <= 1'b1;
            vf_full <= 1'b0;
        end else begin
            case ({s_fire, i_m_fire})
                2'b10: begin
                    o_fill  <= o_fill + 1'b1;
                    o_empty <= 1'b0;
                    vf_full <= (o_fill == vfifo_pkg::fill_t'(vfifo_pkg::MEM_WORDS - 1));
                end
                2'b01: begin
                    o_fill  <= o_fill - 1'b1;
                    vf_full <= 1'b0;
                    o_empty <= (o_fill == vfifo_pkg::fill_t'(1));
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory ledgers in bursts
    ////////////////////////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || ledger.hold) begin
            mem_space <= vfifo_pkg::burst_cnt_t'(vfifo_pkg::MEM_BURSTS);
            mem_data  <= '0;
        end else begin
            // Space is committed on issue and freed once read back
            mem_space <= mem_space - ledger.wr_issue + ledger.rd_done;
            // Data is readable only after its write response
            mem_data  <= mem_data + ledger.wr_done - ledger.rd_issue;
        end
    end

    assign ledger.space_ok = (mem_space != '0);
    assign ledger.data_ok  = (mem_data != '0);

    ////////////////////////////////////////////////////////////
    // Stream protocol overflow
    ////////////////////////////////////////////////////////////
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            s_stalled <= 1'b0;
        end else begin
            s_stalled <= i_s_tvalid && !o_s_tready;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (i_s_tvalid) begin
            s_last_data <= i_s_tdata;
        end
    end

    // Stalled word withdrawn or changed
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || ledger.hold) begin
            o_overflow <= 1'b0;
        end else if (s_stalled && (!i_s_tvalid || i_s_tdata != s_last_data)) begin
            o_overflow <= 1'b1;
        end
    end

    // Reads can never return more bursts than were written
    a_space_bound: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        mem_space <= vfifo_pkg::burst_cnt_t'(vfifo_pkg::MEM_BURSTS));

endmodule

// ==== hdl/vfifo_top.sv ====
module vfifo_top (
    input  logic              S_AXI_ACLK,
    input  logic              S_AXI_ARESETN,
    input  logic              i_soft_reset,
    // Stream in
    input  logic              i_s_axis_tvalid,
    output logic              o_s_axis_tready,
    input  vfifo_pkg::data_t  i_s_axis_tdata,
    // Stream out
    output logic              o_m_axis_tvalid,
    input  logic              i_m_axis_tready,
    output vfifo_pkg::data_t  o_m_axis_tdata,
    // AXI write address
    output logic              o_m_axi_awvalid,
    input  logic              i_m_axi_awready,
    output vfifo_pkg::addr_t  o_m_axi_awaddr,
    output vfifo_pkg::axlen_t o_m_axi_awlen,
    output logic [2:0]        o_m_axi_awsize,
    output logic [1:0]        o_m_axi_awburst,
    // AXI write data and response
    output logic              o_m_axi_wvalid,
    input  logic              i_m_axi_wready,
    output vfifo_pkg::data_t  o_m_axi_wdata,
    output logic              o_m_axi_wlast,
    input  logic              i_m_axi_bvalid,
    output logic              o_m_axi_bready,
    // AXI read address
    output logic              o_m_axi_arvalid,
    input  logic              i_m_axi_arready,
    output vfifo_pkg::addr_t  o_m_axi_araddr,
    output vfifo_pkg::axlen_t o_m_axi_arlen,
    output logic [2:0]        o_m_axi_arsize,
    output logic [1:0]        o_m_axi_arburst,
    // AXI read data
    input  logic              i_m_axi_rvalid,
    output logic              o_m_axi_rready,
    input  vfifo_pkg::data_t  i_m_axi_rdata,
    input  logic              i_m_axi_rlast,
    // Status
    output vfifo_pkg::fill_t  o_fill,
    output logic              o_empty,
    output logic              o_overflow
);

    vfifo_ledger_if ledger ();

    logic                 fifo_clr;
    logic                 ififo_full;
    logic                 ififo_pop;
    vfifo_pkg::fifo_cnt_t ififo_count;
    vfifo_pkg::data_t     ififo_data;
    logic                 ofifo_empty;
    logic                 m_fire;

    // Constant burst shape, responses always taken
    assign o_m_axi_awlen   = vfifo_pkg::AXLEN;
    assign o_m_axi_awsize  = vfifo_pkg::AXSIZE;
    assign o_m_axi_awburst = vfifo_pkg::AXBURST_INCR;
    assign o_m_axi_arlen   = vfifo_pkg::AXLEN;
    assign o_m_axi_arsize  = vfifo_pkg::AXSIZE;
    assign o_m_axi_arburst = vfifo_pkg::AXBURST_INCR;
    assign o_m_axi_bready  = 1'b1;
    assign o_m_axi_rready  = 1'b1;

    assign o_m_axis_tvalid = !ofifo_empty;
    assign m_fire          = o_m_axis_tvalid && i_m_axis_tready;

    vfifo_ctrl u_ctrl (
        .S_AXI_ACLK, .S_AXI_ARESETN, .i_soft_reset,
        .i_s_tvalid(i_s_axis_tvalid), .i_s_tdata(i_s_axis_tdata),
        .i_ififo_full(ififo_full), .o_s_tready(o_s_axis_tready),
        .i_m_fire(m_fire), .o_fifo_clr(fifo_clr),
        .o_fill, .o_empty, .o_overflow, .ledger(ledger.ctrl)
    );

    // Stream into the input FIFO
    sync_fifo ififo (
        .S_AXI_ACLK, .S_AXI_ARESETN, .i_clr(fifo_clr),
        .i_push(i_s_axis_tvalid && o_s_axis_tready), .i_data(i_s_axis_tdata),
        .o_full(ififo_full), .o_count(ififo_count),
        .i_pop(ififo_pop), .o_data(ififo_data), .o_empty()
    );

    burst_writer u_writer (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .i_ififo_count(ififo_count), .i_ififo_data(ififo_data), .o_ififo_pop(ififo_pop),
        .o_awvalid(o_m_axi_awvalid), .i_awready(i_m_axi_awready),
        .o_awaddr(o_m_axi_awaddr),
        .o_wvalid(o_m_axi_wvalid), .i_wready(i_m_axi_wready),
        .o_wdata(o_m_axi_wdata), .o_wlast(o_m_axi_wlast),
        .i_bvalid(i_m_axi_bvalid), .ledger(ledger.writer)
    );

    burst_reader u_reader (
        .S_AXI_ACLK, .S_AXI_ARESETN, .i_m_fire(m_fire),
        .o_arvalid(o_m_axi_arvalid), .i_arready(i_m_axi_arready),
        .o_araddr(o_m_axi_araddr),
        .i_rvalid(i_m_axi_rvalid), .i_rlast(i_m_axi_rlast), .ledger(ledger.reader)
    );

    // R beats into the output FIFO
    sync_fifo ofifo (
        .S_AXI_ACLK, .S_AXI_ARESETN, .i_clr(fifo_clr),
        .i_push(i_m_axi_rvalid), .i_data(i_m_axi_rdata),
        .o_full(), .o_count(),
        .i_pop(m_fire), .o_data(o_m_axis_tdata), .o_empty(ofifo_empty)
    );

endmodule

// ==== verif/axi_mem_model.sv ====
module axi_mem_model (
    input  logic             S_AXI_ACLK,
    input  logic             S_AXI_ARESETN,
    // Write address
    input  logic             i_awvalid,
    output logic             o_awready,
    input  vfifo_pkg::addr_t i_awaddr,
    // Write data and response
    input  logic             i_wvalid,
    output logic             o_wready,
    input  vfifo_pkg::data_t i_wdata,
    input  logic             i_wlast,
    output logic             o_bvalid,
    input  logic             i_bready,
    // Read address
    input  logic             i_arvalid,
    output logic             o_arready,
    input  vfifo_pkg::addr_t i_araddr,
    // Read data
    output logic             o_rvalid,
    input  logic             i_rready,
    output vfifo_pkg::data_t o_rdata,
    output logic             o_rlast
);

    timeunit 1ns;
    timeprecision 100ps;

    vfifo_pkg::data_t mem [vfifo_pkg::MEM_WORDS];

    // Accepted burst addresses waiting for their beats
    vfifo_pkg::addr_t aw_q[$];
    vfifo_pkg::addr_t ar_q[$];
    int               w_cnt;
    int               r_cnt;

    function automatic logic [9:0] word_index(vfifo_pkg::addr_t base, int beat);
        return base[vfifo_pkg::ADDR_W-1:vfifo_pkg::ADDR_LSB] + 10'(beat);
    endfunction

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////
    always @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            o_bvalid  <= 1'b0;
            aw_q.delete();
            w_cnt = 0;
        end else begin
            if (o_bvalid && i_bready) begin
                o_bvalid <= 1'b0;
            end
            if (i_awvalid && o_awready) begin
                aw_q.push_back(i_awaddr);
            end
            // W beats land at the head burst address
            if (i_wvalid && o_wready) begin
                mem[word_index(aw_q[0], w_cnt)] <= i_wdata;
                w_cnt = w_cnt + 1;
                if (i_wlast) begin
                    void'(aw_q.pop_front());
                    w_cnt = 0;
                    o_bvalid <= 1'b1;
                end
            end
            o_awready <= ($urandom % 4) != 0;
            // Data only after its address is known
            o_wready  <= (($urandom % 4) != 0) && (aw_q.size() != 0);
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////
    always @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
            o_rlast   <= 1'b0;
            o_rdata   <= '0;
            ar_q.delete();
            r_cnt = 0;
        end else begin
            if (i_arvalid && o_arready) begin
                ar_q.push_back(i_araddr);
            end
            if (o_rvalid && i_rready) begin
                r_cnt = r_cnt + 1;
                if (o_rlast) begin
                    void'(ar_q.pop_front());
                    r_cnt = 0;
                end
            end
            o_arready <= (($urandom % 4) != 0) && (ar_q.size() < 4);
            if ((!o_rvalid || i_rready) && ar_q.size() != 0 && ($urandom % 3) != 0) begin
                o_rvalid <= 1'b1;
                o_rdata  <= mem[word_index(ar_q[0], r_cnt)];
                o_rlast  <= (r_cnt == vfifo_pkg::BURST_LEN - 1);
            end else if (i_rready) begin
                o_rvalid <= 1'b0;
                o_rlast  <= 1'b0;
            end
        end
    end

endmodule

// ==== verif/tb_vfifo.sv ====
module tb_vfifo;

    timeunit 1ns;
    timeprecision 100ps;

    // Words offered over the whole run, the stalled one included
    localparam int TOTAL_WORDS = 320 + 24 + 1024 + 1 + 48 + 64;
    localparam int MAX_CYCLES  = 20 * TOTAL_WORDS + 2000;

    logic clk = 1'b0;
    logic rstn;
    logic soft_reset;
    logic s_tvalid, s_tready, m_tvalid, m_tready;
    vfifo_pkg::data_t s_tdata, m_tdata;
    logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic arvalid, arready, rvalid, rready, rlast;
    vfifo_pkg::addr_t awaddr, araddr;
    vfifo_pkg::data_t wdata, rdata;
    vfifo_pkg::axlen_t awlen, arlen;
    logic [2:0] awsize, arsize;
    logic [1:0] awburst, arburst;
    vfifo_pkg::fill_t fill;
    logic empty, overflow;

    // Accepted words still owed by the output
    vfifo_pkg::data_t exp_q[$];
    int n_in;
    int n_start;
    int n_cycles;
    // Output ready: 0 low, 1 high, 2 random
    int out_mode;
    logic random_gaps;

    always #4 clk = ~clk;

    vfifo_top DUT (
        .S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn), .i_soft_reset(soft_reset),
        .i_s_axis_tvalid(s_tvalid), .o_s_axis_tready(s_tready), .i_s_axis_tdata(s_tdata),
        .o_m_axis_tvalid(m_tvalid), .i_m_axis_tready(m_tready), .o_m_axis_tdata(m_tdata),
        .o_m_axi_awvalid(awvalid), .i_m_axi_awready(awready), .o_m_axi_awaddr(awaddr),
        .o_m_axi_awlen(awlen), .o_m_axi_awsize(awsize), .o_m_axi_awburst(awburst),
        .o_m_axi_wvalid(wvalid), .i_m_axi_wready(wready), .o_m_axi_wdata(wdata),
        .o_m_axi_wlast(wlast), .i_m_axi_bvalid(bvalid), .o_m_axi_bready(bready),
        .o_m_axi_arvalid(arvalid), .i_m_axi_arready(arready), .o_m_axi_araddr(araddr),
        .o_m_axi_arlen(arlen), .o_m_axi_arsize(arsize), .o_m_axi_arburst(arburst),
        .i_m_axi_rvalid(rvalid), .o_m_axi_rready(rready), .i_m_axi_rdata(rdata),
        .i_m_axi_rlast(rlast),
        .o_fill(fill), .o_empty(empty), .o_overflow(overflow)
    );

    axi_mem_model u_mem (
        .S_AXI_ACLK(clk), .S_AXI_ARESETN(rstn),
        .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
        .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wlast(wlast),
        .o_bvalid(bvalid), .i_bready(bready),
        .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
        .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rlast(rlast)
    );

    ////////////////////////////////////////////////////////////
    // Reference and compare tasks
    ////////////////////////////////////////////////////////////

    // Stream order is preserved so the oldest accepted word is next
    function automatic vfifo_pkg::data_t ref_word();
        return exp_q.pop_front();
    endfunction

    task automatic check_word(input vfifo_pkg::data_t got, input vfifo_pkg::data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: output word %h, expected %h", $time, got, exp);
            $display("Result: FAILED");
            $fatal(1, "output word mismatch");
        end
    endtask

    task automatic check_fill(input vfifo_pkg::fill_t got, input vfifo_pkg::fill_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: fill %0d, expected %0d", $time, got, exp);
            $display("Result: FAILED");
            $fatal(1, "fill count mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Eight beats of one 32-bit word, incrementing
    // AXI length is beats less one and size is log2 of the bytes per beat
    task automatic check_burst_shape(input vfifo_pkg::axlen_t len, input logic [2:0] size,
                                     input logic [1:0] burst);
        if (len !== 8'd7 || size !== 3'd2 || burst !== 2'b01) begin
            $display("[ERROR] %0t ns: burst len %0d size %0d type %b, expected 7 2 01",
                     $time, len, size, burst);
            $display("Result: FAILED");
            $fatal(1, "burst attribute mismatch");
        end
    endtask

    // Both stream handshakes seen at the edge where they happen
    always @(posedge clk) begin
        if (rstn && s_tvalid && s_tready) begin
            exp_q.push_back(s_tdata);
            n_in++;
        end
        if (rstn && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                $display("An output word %h appeared that was never accepted", m_tdata);
                $display("Result: FAILED");
                $fatal(1, "unexpected output word");
            end else begin
                check_word(m_tdata, ref_word());
            end
        end
        // Burst shape on every address handshake
        if (rstn && awvalid && awready) begin
            check_burst_shape(awlen, awsize, awburst);
        end
        if (rstn && arvalid && arready) begin
            check_burst_shape(arlen, arsize, arburst);
        end
        // Responses and read data are never held off
        if (rstn) begin
            check_flag(bready, 1'b1, "M_AXI_BREADY");
            check_flag(rready, 1'b1, "M_AXI_RREADY");
        end
    end

    // Output ready pattern
    always @(negedge clk) begin
        m_tready <= (out_mode == 1) || (out_mode == 2 && ($urandom % 3) != 0);
    end

    always @(posedge clk) begin
        n_cycles++;
        if (n_cycles > MAX_CYCLES) begin
            $display("The run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////
    task automatic send_word(input vfifo_pkg::data_t d);
        int n0;
        n0 = n_in;
        s_tvalid = 1'b1;
        s_tdata  = d;
        do @(negedge clk); while (n_in == n0);
        s_tvalid = 1'b0;
        if (random_gaps) begin
            repeat ($urandom % 3) @(negedge clk);
        end
    endtask

    task automatic send_words(input int n);
        for (int i = 0; i < n; i++) begin
            send_word($urandom);
        end
    endtask

    task automatic drain();
        out_mode = 1;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'hdc7f));
        rstn        = 1'b0;
        soft_reset  = 1'b0;
        s_tvalid    = 1'b0;
        s_tdata     = '0;
        m_tready    = 1'b0;
        out_mode    = 0;
        random_gaps = 1'b0;
        n_in        = 0;
        n_start     = 0;
        n_cycles    = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        while (!s_tready) @(negedge clk);

        // Random traffic, 40 bursts
        random_gaps = 1'b1;
        out_mode    = 2;
        send_words(40 * vfifo_pkg::BURST_LEN);
        drain();

        // Fill count while the output is blocked
        random_gaps = 1'b0;
        out_mode    = 0;
        idle_cycles(3);
        send_words(24);
        idle_cycles(300);
        check_fill(fill, vfifo_pkg::fill_t'(24));
        check_flag(empty, 1'b0, "o_empty");
        drain();
        check_fill(fill, '0);
        check_flag(empty, 1'b1, "o_empty");

        // Fill to capacity
        out_mode = 0;
        idle_cycles(3);
        n_start = n_in;
        send_words(vfifo_pkg::MEM_WORDS);
        s_tvalid = 1'b1;
        s_tdata  = $urandom;
        repeat (200) begin
            @(negedge clk);
            check_flag(s_tready, 1'b0, "S_AXIS_TREADY");
        end
        // Exactly the capacity was taken in
        check_fill(vfifo_pkg::fill_t'(n_in - n_start),
                   vfifo_pkg::fill_t'(vfifo_pkg::MEM_WORDS));
        check_fill(fill, vfifo_pkg::fill_t'(vfifo_pkg::MEM_WORDS));
        // A held word with stable data is no overflow
        check_flag(overflow, 1'b0, "o_overflow");

        // Stalled word withdrawn
        s_tvalid = 1'b0;
        idle_cycles(2);
        check_flag(overflow, 1'b1, "o_overflow");
        drain();
        check_fill(fill, '0);

        // Soft reset in the middle of traffic
        random_gaps = 1'b1;
        out_mode    = 2;
        send_words(48);
        out_mode = 0;
        idle_cycles(3);
        soft_reset = 1'b1;
        @(negedge clk);
        soft_reset = 1'b0;
        @(negedge clk);
        while (!s_tready) @(negedge clk);
        exp_q.delete();
        check_fill(fill, '0);
        check_flag(empty, 1'b1, "o_empty");
        check_flag(overflow, 1'b0, "o_overflow");
        out_mode = 2;
        idle_cycles(50);

        // Fresh data after the soft reset
        send_words(64);
        drain();

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
common/vfifo_pkg.sv
common/vfifo_ledger_if.sv
hdl/sync_fifo.sv
hdl/vfifo_ctrl.sv
burst_writer/burst_writer.sv
burst_reader/burst_reader.sv
hdl/vfifo_top.sv
verif/axi_mem_model.sv
verif/tb_vfifo.sv
